//--- verilog/soc_pkg.sv
package soc_pkg;

// Bus geometry
parameter int ADDR_W = 32;
parameter int DATA_W = 32;
parameter int STRB_W = DATA_W / 8;

// Confreg page decoded on the upper 16 address bits
parameter logic [ADDR_W-1:0] CONFREG_BASE = 32'hbfaf_0000;

parameter logic [15:0] CR_LED_OFS     = 16'hf000;
parameter logic [15:0] CR_LED_RG0_OFS = 16'hf004;
parameter logic [15:0] CR_LED_RG1_OFS = 16'hf008;
parameter logic [15:0] CR_SWITCH_OFS  = 16'hf020;
parameter logic [15:0] CR_TIMER_OFS   = 16'he000;

parameter int LED_W    = 16;
parameter int SWITCH_W = 8;

typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_decerr = 2'b11
} bus_resp_e;

typedef enum logic [1:0] {
    tgt_ram,
    tgt_confreg,
    tgt_decerr
} xbar_target_e;

endpackage

//--- verilog/bus_if.sv
`timescale 1ns/100ps

interface bus_if import soc_pkg::*; ();

// Read request
logic              ar_valid;
logic [ADDR_W-1:0] ar_addr;
logic              ar_ready;

// Read data
logic              r_valid;
logic [DATA_W-1:0] r_data;
bus_resp_e         r_resp;
logic              r_ready;

// Write address and data together
logic              w_valid;
logic [ADDR_W-1:0] w_addr;
logic [DATA_W-1:0] w_data;
logic [STRB_W-1:0] w_strb;
logic              w_ready;

// Write response
logic              b_valid;
bus_resp_e         b_resp;
logic              b_ready;

modport master (
    output ar_valid, ar_addr, r_ready, w_valid, w_addr, w_data, w_strb, b_ready,
    input  ar_ready, r_valid, r_data, r_resp, w_ready, b_valid, b_resp
);

modport slave (
    input  ar_valid, ar_addr, r_ready, w_valid, w_addr, w_data, w_strb, b_ready,
    output ar_ready, r_valid, r_data, r_resp, w_ready, b_valid, b_resp
);

endinterface

//--- verilog/bus_crossbar_1x2.sv
`timescale 1ns/100ps

module bus_crossbar_1x2 import soc_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic              cpu_clk,
    input  logic              rst,
    input  logic              ar_valid,
    input  logic [ADDR_W-1:0] ar_addr,
    output logic              ar_ready,
    output logic              r_valid,
    output logic [DATA_W-1:0] r_data,
    output bus_resp_e         r_resp,
    input  logic              r_ready,
    input  logic              w_valid,
    input  logic [ADDR_W-1:0] w_addr,
    input  logic [DATA_W-1:0] w_data,
    input  logic [STRB_W-1:0] w_strb,
    output logic              w_ready,
    output logic              b_valid,
    output bus_resp_e         b_resp,
    input  logic              b_ready,
    bus_if.master             ram_bus,
    bus_if.master             cfg_bus
);

localparam logic [ADDR_W-1:0] RAM_BYTES = ADDR_W'(RAM_WORDS * 4);

xbar_target_e ar_tgt;
xbar_target_e w_tgt;
xbar_target_e rd_tgt;
xbar_target_e wr_tgt;
logic         rd_busy;
logic         wr_busy;
logic         ar_sel_ready;
logic         w_sel_ready;

function automatic xbar_target_e decode(input logic [ADDR_W-1:0] addr);
    if (addr[ADDR_W-1:16] == CONFREG_BASE[ADDR_W-1:16])
        return tgt_confreg;
    else if (addr < RAM_BYTES)
        return tgt_ram;
    else
        return tgt_decerr;
endfunction

assign ar_tgt = decode(ar_addr);
assign w_tgt  = decode(w_addr);

// Requests go out only while the channel has nothing outstanding
assign ram_bus.ar_valid = ar_valid && !rd_busy && (ar_tgt == tgt_ram);
assign cfg_bus.ar_valid = ar_valid && !rd_busy && (ar_tgt == tgt_confreg);
assign ram_bus.ar_addr  = ar_addr;
assign cfg_bus.ar_addr  = ar_addr;

assign ram_bus.w_valid = w_valid && !wr_busy && (w_tgt == tgt_ram);
assign cfg_bus.w_valid = w_valid && !wr_busy && (w_tgt == tgt_confreg);
assign ram_bus.w_addr  = w_addr;
assign cfg_bus.w_addr  = w_addr;
assign ram_bus.w_data  = w_data;
assign cfg_bus.w_data  = w_data;
assign ram_bus.w_strb  = w_strb;
assign cfg_bus.w_strb  = w_strb;

always_comb begin
    case (ar_tgt)
        tgt_ram:     ar_sel_ready = ram_bus.ar_ready;
        tgt_confreg: ar_sel_ready = cfg_bus.ar_ready;
        default:     ar_sel_ready = 1'b1;
    endcase
    case (w_tgt)
        tgt_ram:     w_sel_ready = ram_bus.w_ready;
        tgt_confreg: w_sel_ready = cfg_bus.w_ready;
        default:     w_sel_ready = 1'b1;
    endcase
end

assign ar_ready = !rd_busy && ar_sel_ready;
assign w_ready  = !wr_busy && w_sel_ready;

always_ff @(posedge cpu_clk) begin
    if (rst) begin
        rd_busy <= 1'b0;
        wr_busy <= 1'b0;
        rd_tgt  <= tgt_ram;
        wr_tgt  <= tgt_ram;
    end else begin
        if (ar_valid && ar_ready) begin
            rd_busy <= 1'b1;
            rd_tgt  <= ar_tgt;
        end else if (r_valid && r_ready) begin
            rd_busy <= 1'b0;
        end
        if (w_valid && w_ready) begin
            wr_busy <= 1'b1;
            wr_tgt  <= w_tgt;
        end else if (b_valid && b_ready) begin
            wr_busy <= 1'b0;
        end
    end
end

// Responses come back from the recorded target
assign ram_bus.r_ready = r_ready && (rd_tgt == tgt_ram);
assign cfg_bus.r_ready = r_ready && (rd_tgt == tgt_confreg);
assign ram_bus.b_ready = b_ready && (wr_tgt == tgt_ram);
assign cfg_bus.b_ready = b_ready && (wr_tgt == tgt_confreg);

always_comb begin
    case (rd_tgt)
        tgt_ram: begin
            r_valid = ram_bus.r_valid;
            r_data  = ram_bus.r_data;
            r_resp  = ram_bus.r_resp;
        end
        tgt_confreg: begin
            r_valid = cfg_bus.r_valid;
            r_data  = cfg_bus.r_data;
            r_resp  = cfg_bus.r_resp;
        end
        default: begin
            // Busy flag doubles as the decode error response
            r_valid = rd_busy;
            r_data  = '0;
            r_resp  = resp_decerr;
        end
    endcase
    case (wr_tgt)
        tgt_ram: begin
            b_valid = ram_bus.b_valid;
            b_resp  = ram_bus.b_resp;
        end
        tgt_confreg: begin
            b_valid = cfg_bus.b_valid;
            b_resp  = cfg_bus.b_resp;
        end
        default: begin
            b_valid = wr_busy;
            b_resp  = resp_decerr;
        end
    endcase
end

endmodule

//--- verilog/ram_slave.sv
`timescale 1ns/100ps

module ram_slave import soc_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic cpu_clk,
    input  logic rst,
    bus_if.slave bus
);

localparam int IDX_W = $clog2(RAM_WORDS);

logic [DATA_W-1:0] mem [RAM_WORDS];
logic [IDX_W-1:0]  rd_idx;
logic [IDX_W-1:0]  wr_idx;
logic              rd_accept;
logic              wr_accept;

// Word index wraps around the memory depth
assign rd_idx = bus.ar_addr[IDX_W+1:2];
assign wr_idx = bus.w_addr[IDX_W+1:2];

assign bus.ar_ready = !bus.r_valid;
assign bus.w_ready  = !bus.b_valid;
assign rd_accept    = bus.ar_valid && bus.ar_ready;
assign wr_accept    = bus.w_valid && bus.w_ready;

assign bus.r_resp = resp_okay;
assign bus.b_resp = resp_okay;

always_ff @(posedge cpu_clk) begin
    if (rst) begin
        bus.r_valid <= 1'b0;
        bus.b_valid <= 1'b0;
    end else begin
        if (rd_accept)
            bus.r_valid <= 1'b1;
        else if (bus.r_ready)
            bus.r_valid <= 1'b0;
        if (wr_accept)
            bus.b_valid <= 1'b1;
        else if (bus.b_ready)
            bus.b_valid <= 1'b0;
    end
end

always_ff @(posedge cpu_clk) begin
    if (rd_accept)
        bus.r_data <= mem[rd_idx];
    if (wr_accept) begin
        for (int b = 0; b < STRB_W; b++) begin
            if (bus.w_strb[b])
                mem[wr_idx][b*8 +: 8] <= bus.w_data[b*8 +: 8];
        end
    end
end

endmodule

//--- verilog/confreg.sv
`timescale 1ns/100ps

module confreg import soc_pkg::*; (
    input  logic                cpu_clk,
    input  logic                rst,
    bus_if.slave                bus,
    output logic [LED_W-1:0]    led,
    output logic [1:0]          led_rg0,
    output logic [1:0]          led_rg1,
    input  logic [SWITCH_W-1:0] switch
);

logic [LED_W-1:0]  led_data;
logic [DATA_W-1:0] led_rg0_data;
logic [DATA_W-1:0] led_rg1_data;
logic [31:0]       timer;
logic [DATA_W-1:0] rd_value;
logic              rd_accept;
logic              wr_accept;

assign bus.ar_ready = !bus.r_valid;
assign bus.w_ready  = !bus.b_valid;
assign rd_accept    = bus.ar_valid && bus.ar_ready;
assign wr_accept    = bus.w_valid && bus.w_ready;

assign bus.r_resp = resp_okay;
assign bus.b_resp = resp_okay;

// LEDs on the board light when driven low
assign led     = ~led_data;
assign led_rg0 = led_rg0_data[1:0];
assign led_rg1 = led_rg1_data[1:0];

always_comb begin
    case (bus.ar_addr[15:0])
        CR_LED_OFS:     rd_value = DATA_W'(led_data);
        CR_LED_RG0_OFS: rd_value = led_rg0_data;
        CR_LED_RG1_OFS: rd_value = led_rg1_data;
        CR_SWITCH_OFS:  rd_value = DATA_W'(switch);
        CR_TIMER_OFS:   rd_value = DATA_W'(timer);
        default:        rd_value = '0;
    endcase
end

always_ff @(posedge cpu_clk) begin
    if (rst) begin
        bus.r_valid  <= 1'b0;
        bus.b_valid  <= 1'b0;
        led_data     <= '0;
        led_rg0_data <= '0;
        led_rg1_data <= '0;
        timer        <= '0;
    end else begin
        timer <= timer + 32'd1;
        if (rd_accept)
            bus.r_valid <= 1'b1;
        else if (bus.r_ready)
            bus.r_valid <= 1'b0;
        if (wr_accept)
            bus.b_valid <= 1'b1;
        else if (bus.b_ready)
            bus.b_valid <= 1'b0;
        // Whole-word writes that ignore the strobes
        if (wr_accept) begin
            case (bus.w_addr[15:0])
                CR_LED_OFS:     led_data     <= bus.w_data[LED_W-1:0];
                CR_LED_RG0_OFS: led_rg0_data <= bus.w_data;
                CR_LED_RG1_OFS: led_rg1_data <= bus.w_data;
                default:        ;
            endcase
        end
    end
end

always_ff @(posedge cpu_clk) begin
    if (rd_accept)
        bus.r_data <= rd_value;
end

endmodule

//--- verilog/soc_top.sv
`timescale 1ns/100ps

module soc_top import soc_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                cpu_clk,
    input  logic                rst,
    // Master port
    input  logic                ar_valid,
    input  logic [ADDR_W-1:0]   ar_addr,
    output logic                ar_ready,
    output logic                r_valid,
    output logic [DATA_W-1:0]   r_data,
    output bus_resp_e           r_resp,
    input  logic                r_ready,
    input  logic                w_valid,
    input  logic [ADDR_W-1:0]   w_addr,
    input  logic [DATA_W-1:0]   w_data,
    input  logic [STRB_W-1:0]   w_strb,
    output logic                w_ready,
    output logic                b_valid,
    output bus_resp_e           b_resp,
    input  logic                b_ready,
    // Board I/O
    output logic [LED_W-1:0]    led,
    output logic [1:0]          led_rg0,
    output logic [1:0]          led_rg1,
    input  logic [SWITCH_W-1:0] switch
);

bus_if ram_bus ();
bus_if cfg_bus ();

bus_crossbar_1x2 #(
    .RAM_WORDS ( RAM_WORDS )
) u_crossbar (
    .cpu_clk,
    .rst,
    .ar_valid,
    .ar_addr,
    .ar_ready,
    .r_valid,
    .r_data,
    .r_resp,
    .r_ready,
    .w_valid,
    .w_addr,
    .w_data,
    .w_strb,
    .w_ready,
    .b_valid,
    .b_resp,
    .b_ready,
    .ram_bus ( ram_bus.master ),
    .cfg_bus ( cfg_bus.master )
);

ram_slave #(
    .RAM_WORDS ( RAM_WORDS )
) u_ram (
    .cpu_clk,
    .rst,
    .bus ( ram_bus.slave )
);

confreg u_confreg (
    .cpu_clk,
    .rst,
    .bus ( cfg_bus.slave ),
    .led,
    .led_rg0,
    .led_rg1,
    .switch
);

endmodule

//--- sim/soc_assertions.sv
`timescale 1ns/100ps

module soc_assertions import soc_pkg::*; (
    input logic              cpu_clk,
    input logic              rst,
    input logic              ar_valid,
    input logic              ar_ready,
    input logic              r_valid,
    input logic [DATA_W-1:0] r_data,
    input bus_resp_e         r_resp,
    input logic              r_ready,
    input logic              w_valid,
    input logic              w_ready,
    input logic              b_valid,
    input bus_resp_e         b_resp,
    input logic              b_ready
);

// Stalled responses keep valid and payload
r_hold: assert property (@(posedge cpu_clk) disable iff (rst)
    r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_resp))
    else $error("r_valid dropped or read payload changed while stalled");

b_hold: assert property (@(posedge cpu_clk) disable iff (rst)
    b_valid && !b_ready |=> b_valid && $stable(b_resp))
    else $error("b_valid dropped or write response changed while stalled");

// One cycle from accept to response
r_latency: assert property (@(posedge cpu_clk) disable iff (rst)
    ar_valid && ar_ready |=> $rose(r_valid))
    else $error("r_valid did not rise one cycle after a read accept");

b_latency: assert property (@(posedge cpu_clk) disable iff (rst)
    w_valid && w_ready |=> $rose(b_valid))
    else $error("b_valid did not rise one cycle after a write accept");

endmodule

bind soc_top soc_assertions u_assertions (.*);

//--- sim/tb_soc_top.sv
`timescale 1ns/100ps

module tb_soc_top import soc_pkg::*; ();

localparam int RAM_WORDS = 1024;
localparam int RAM_IDX_W = $clog2(RAM_WORDS);
localparam logic [ADDR_W-1:0] RAM_BYTES = ADDR_W'(RAM_WORDS * 4);
localparam int CLK_PERIOD = 40;
localparam int NUM_RAM = 16;
localparam int NUM_XFERS = 3 * NUM_RAM + 20;
localparam int MAX_CYCLES_PER_XFER = 64;

logic                cpu_clk;
logic                rst;
logic                ar_valid;
logic [ADDR_W-1:0]   ar_addr;
logic                ar_ready;
logic                r_valid;
logic [DATA_W-1:0]   r_data;
bus_resp_e           r_resp;
logic                r_ready;
logic                w_valid;
logic [ADDR_W-1:0]   w_addr;
logic [DATA_W-1:0]   w_data;
logic [STRB_W-1:0]   w_strb;
logic                w_ready;
logic                b_valid;
bus_resp_e           b_resp;
logic                b_ready;
logic [LED_W-1:0]    led;
logic [1:0]          led_rg0;
logic [1:0]          led_rg1;
logic [SWITCH_W-1:0] switch;

// Reference state
logic [DATA_W-1:0] mem_ref [RAM_WORDS];
logic [LED_W-1:0]  led_ref = '0;
logic [DATA_W-1:0] rg0_ref = '0;
logic [DATA_W-1:0] rg1_ref = '0;
logic [31:0]       lfsr = 32'h584c9055;

logic [DATA_W-1:0] rd_data_q [$];
logic [DATA_W-1:0] rd_mask_q [$];
bus_resp_e         rd_resp_q [$];
bus_resp_e         wr_resp_q [$];
logic [DATA_W-1:0] last_rdata;

soc_top #(
    .RAM_WORDS ( RAM_WORDS )
) dut (.*);

initial begin
    cpu_clk = 1'b0;
    forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
end

task automatic halt_on_error(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
    if (act !== exp)
        halt_on_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
endtask

task automatic check_resp(input string name, input bus_resp_e exp, input bus_resp_e act);
    if (act !== exp)
        halt_on_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
endtask

task automatic check_led(input string name, input logic [LED_W-1:0] exp,
                         input logic [LED_W-1:0] act);
    if (act !== exp)
        halt_on_error($sformatf("Fail %s expected %h actual %h", name, exp, act));
endtask

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_step(lfsr);
        v = {v[30:0], lfsr[0]};
    end
    return v;
endfunction

function automatic logic [ADDR_W-1:0] cr_addr(input logic [15:0] ofs);
    return {CONFREG_BASE[ADDR_W-1:16], ofs};
endfunction

function automatic xbar_target_e addr_region(input logic [ADDR_W-1:0] addr);
    if (addr[ADDR_W-1:16] == CONFREG_BASE[ADDR_W-1:16])
        return tgt_confreg;
    if (addr < RAM_BYTES)
        return tgt_ram;
    return tgt_decerr;
endfunction

function automatic bus_resp_e ref_resp(input logic [ADDR_W-1:0] addr);
    return (addr_region(addr) == tgt_decerr) ? resp_decerr : resp_okay;
endfunction

// Expected read data from the reference state
function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
    if (addr_region(addr) == tgt_ram)
        return mem_ref[addr[RAM_IDX_W+1:2]];
    if (addr_region(addr) == tgt_confreg) begin
        case (addr[15:0])
            CR_LED_OFS:     return DATA_W'(led_ref);
            CR_LED_RG0_OFS: return rg0_ref;
            CR_LED_RG1_OFS: return rg1_ref;
            CR_SWITCH_OFS:  return DATA_W'(switch);
            default:        return '0;
        endcase
    end
    return '0;
endfunction

task automatic ref_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                         input logic [STRB_W-1:0] strb);
    if (addr_region(addr) == tgt_ram) begin
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b])
                mem_ref[addr[RAM_IDX_W+1:2]][b*8 +: 8] = data[b*8 +: 8];
        end
    end else if (addr_region(addr) == tgt_confreg) begin
        case (addr[15:0])
            CR_LED_OFS:     led_ref = data[LED_W-1:0];
            CR_LED_RG0_OFS: rg0_ref = data;
            CR_LED_RG1_OFS: rg1_ref = data;
            default:        ;
        endcase
    end
endtask

task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                         input logic [STRB_W-1:0] strb);
    logic done;
    @(posedge cpu_clk);
    #2;
    w_valid = 1'b1;
    w_addr  = addr;
    w_data  = data;
    w_strb  = strb;
    wr_resp_q.push_back(ref_resp(addr));
    do @(negedge cpu_clk); while (!w_ready);
    ref_write(addr, data, strb);
    @(posedge cpu_clk);
    #2;
    w_valid = 1'b0;
    do begin
        b_ready = take_bits(1) != 0;
        @(negedge cpu_clk);
        done = b_valid && b_ready;
        @(posedge cpu_clk);
        #2;
    end while (!done);
    b_ready = 1'b0;
endtask

task automatic bus_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] mask);
    logic done;
    @(posedge cpu_clk);
    #2;
    ar_valid = 1'b1;
    ar_addr  = addr;
    rd_data_q.push_back(ref_read(addr));
    rd_mask_q.push_back(mask);
    rd_resp_q.push_back(ref_resp(addr));
    do @(negedge cpu_clk); while (!ar_ready);
    @(posedge cpu_clk);
    #2;
    ar_valid = 1'b0;
    do begin
        r_ready = take_bits(1) != 0;
        @(negedge cpu_clk);
        done = r_valid && r_ready;
        @(posedge cpu_clk);
        #2;
    end while (!done);
    r_ready = 1'b0;
endtask

// Handshakes are sampled mid-cycle
always @(negedge cpu_clk) begin : compare_responses
    logic              rd_accepted;
    logic              wr_accepted;
    logic              r_stalled;
    logic              b_stalled;
    logic [DATA_W-1:0] r_data_held;
    bus_resp_e         b_resp_held;
    logic [DATA_W-1:0] mask;
    if (rst) begin
        rd_accepted = 1'b0;
        wr_accepted = 1'b0;
        r_stalled   = 1'b0;
        b_stalled   = 1'b0;
    end else begin
        if (rd_accepted && !r_valid)
            halt_on_error("r_valid did not rise one cycle after a read accept");
        if (wr_accepted && !b_valid)
            halt_on_error("b_valid did not rise one cycle after a write accept");
        if (r_stalled && (!r_valid || r_data !== r_data_held))
            halt_on_error("read response dropped or changed before r_ready");
        if (b_stalled && (!b_valid || b_resp !== b_resp_held))
            halt_on_error("write response dropped or changed before b_ready");
        rd_accepted = ar_valid && ar_ready;
        wr_accepted = w_valid && w_ready;
        r_stalled   = r_valid && !r_ready;
        b_stalled   = b_valid && !b_ready;
        r_data_held = r_data;
        b_resp_held = b_resp;
        if (r_valid && r_ready) begin
            if (rd_data_q.size() == 0)
                halt_on_error("read response arrived with no read outstanding");
            mask = rd_mask_q.pop_front();
            check_data("r_data", rd_data_q.pop_front() & mask, r_data & mask);
            check_resp("r_resp", rd_resp_q.pop_front(), r_resp);
            last_rdata = r_data;
        end
        if (b_valid && b_ready) begin
            if (wr_resp_q.size() == 0)
                halt_on_error("write response arrived with no write outstanding");
            check_resp("b_resp", wr_resp_q.pop_front(), b_resp);
        end
    end
end

initial begin : watchdog
    #(CLK_PERIOD * (NUM_XFERS * MAX_CYCLES_PER_XFER + 10));
    halt_on_error("watchdog expired, a bus handshake never completed");
end

initial begin : stimulus
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] ram_addrs [$];
    logic [DATA_W-1:0] t_first;
    int                pick;
    rst      = 1'b1;
    ar_valid = 1'b0;
    ar_addr  = '0;
    r_ready  = 1'b0;
    w_valid  = 1'b0;
    w_addr   = '0;
    w_data   = '0;
    w_strb   = '0;
    b_ready  = 1'b0;
    switch   = SWITCH_W'(take_bits(SWITCH_W));
    repeat (2) @(posedge cpu_clk);
    #2;
    rst = 1'b0;

    @(negedge cpu_clk);
    check_led("led", '1, led);
    check_data("led_rg0", '0, DATA_W'(led_rg0));
    check_data("led_rg1", '0, DATA_W'(led_rg1));
    check_data("r_valid", '0, DATA_W'(r_valid));
    check_data("b_valid", '0, DATA_W'(b_valid));
    check_data("ar_ready", 1, DATA_W'(ar_ready));
    check_data("w_ready", 1, DATA_W'(w_ready));

    // Full words first so that no byte stays unknown
    for (int i = 0; i < NUM_RAM; i++) begin
        addr = ADDR_W'(take_bits(RAM_IDX_W)) << 2;
        ram_addrs.push_back(addr);
        bus_write(addr, take_bits(DATA_W), '1);
    end
    for (int i = 0; i < NUM_RAM; i++) begin
        pick = int'(take_bits(8)) % ram_addrs.size();
        bus_write(ram_addrs[pick], take_bits(DATA_W), STRB_W'(take_bits(STRB_W)));
    end
    foreach (ram_addrs[i])
        bus_read(ram_addrs[i], '1);

    bus_write(cr_addr(CR_LED_OFS), take_bits(DATA_W), '1);
    check_led("led", ~led_ref, led);
    bus_write(cr_addr(CR_LED_RG0_OFS), take_bits(DATA_W), '1);
    check_data("led_rg0", DATA_W'(rg0_ref[1:0]), DATA_W'(led_rg0));
    bus_write(cr_addr(CR_LED_RG1_OFS), take_bits(DATA_W), '1);
    check_data("led_rg1", DATA_W'(rg1_ref[1:0]), DATA_W'(led_rg1));
    bus_read(cr_addr(CR_LED_OFS), '1);
    bus_read(cr_addr(CR_LED_RG0_OFS), '1);
    bus_read(cr_addr(CR_LED_RG1_OFS), '1);

    bus_read(cr_addr(CR_SWITCH_OFS), '1);
    bus_write(cr_addr(CR_SWITCH_OFS), take_bits(DATA_W), '1);
    switch = SWITCH_W'(take_bits(SWITCH_W));
    bus_read(cr_addr(CR_SWITCH_OFS), '1);
    bus_read(cr_addr(16'h0100), '1);

    // Would alias onto a written RAM word if the decode were wrong
    for (int i = 0; i < 2; i++) begin
        addr = RAM_BYTES + ram_addrs[i];
        bus_write(addr, take_bits(DATA_W), '1);
        bus_read(addr, '1);
        bus_read(ram_addrs[i], '1);
    end

    // Timer values are masked here and compared below
    bus_read(cr_addr(CR_TIMER_OFS), '0);
    t_first = last_rdata;
    repeat (10) @(posedge cpu_clk);
    bus_read(cr_addr(CR_TIMER_OFS), '0);
    if (last_rdata <= t_first) begin
        halt_on_error("timer did not advance between two reads");
    end else begin
        $display("all tests passed");
        $finish;
    end
end

endmodule

//--- vlog.f
verilog/soc_pkg.sv
verilog/bus_if.sv
verilog/bus_crossbar_1x2.sv
verilog/ram_slave.sv
verilog/confreg.sv
verilog/soc_top.sv
sim/soc_assertions.sv
sim/tb_soc_top.sv
